// ==== list.f ====
+incdir+verilog
verilog/vfirst_pkg.sv
verilog/ctz_tree.sv
verilog/ctz.sv
verilog/mask_chunk_prep.sv
verilog/vfirst_bit.sv
verilog/vfirst_reduce.sv
verilog/vfirst_unit.sv
sim/tb_clock_gen.sv
sim/vfirst_unit_tb.sv

// ==== Bender.yml ====
package:
  name: vfirst_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/vfirst_pkg.sv
      - verilog/ctz_tree.sv
      - verilog/ctz.sv
      - verilog/mask_chunk_prep.sv
      - verilog/vfirst_bit.sv
      - verilog/vfirst_reduce.sv
      - verilog/vfirst_unit.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/tb_clock_gen.sv
      - sim/vfirst_unit_tb.sv

// ==== sim/vfirst_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vfirst_settings.svh"

module vfirst_unit_tb;

  localparam int CHUNK_W       = `VFIRST_CHUNK_W;
  localparam int MAX_ELEMS     = 1 << `VFIRST_IDX_W;
  localparam int NUM_RANDOM    = 40;
  localparam int DRAIN_TIMEOUT = 100;

  logic                   clk;
  logic                   rst;
  logic                   in_valid;
  vfirst_pkg::chunk_req_t in_req;
  logic                   out_valid;
  vfirst_pkg::xlen_t      out_rd;

  logic [31:0]            lfsr_state;
  int                     cycle_cnt = 0;
  bit                     checks_done = 1'b0;
  int                     value_errors = 0;
  int                     timing_errors = 0;
  int                     other_errors = 0;

  // one expected result and its due cycle per instruction
  vfirst_pkg::xlen_t      exp_q[$];
  int                     exp_cycle_q[$];

  tb_clock_gen #(.HALF_PERIOD_NS(4)) u_clk (.clk(clk));

  vfirst_unit i_vfirst_unit (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_req   (in_req),
    .out_valid(out_valid),
    .out_rd   (out_rd)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // each bit is set with probability 1 / 2**k
  function automatic logic [MAX_ELEMS-1:0] sparse_vector(input int k);
    logic [MAX_ELEMS-1:0] v;
    for (int i = 0; i < MAX_ELEMS; i++) begin
      v[i] = (rand_bits(k) == 0);
    end
    return v;
  endfunction

  // lowest element below vl that is set in vs2 and not masked off by v0
  function automatic vfirst_pkg::xlen_t first_active(input logic [MAX_ELEMS-1:0] vs2,
                                                     input logic [MAX_ELEMS-1:0] v0,
                                                     input logic vm, input int vl);
    for (int i = 0; i < MAX_ELEMS; i++) begin
      if (i < vl && vs2[i] && (vm || v0[i])) begin
        return vfirst_pkg::xlen_t'(i);
      end
    end
    return {`VFIRST_XLEN{1'b1}};
  endfunction

  // streams one instruction as consecutive chunks, lowest chunk first
  task automatic send_instr(input logic [MAX_ELEMS-1:0] vs2, input logic [MAX_ELEMS-1:0] v0,
                            input logic vm, input int vl);
    int n_chunks;
    n_chunks = (vl + CHUNK_W - 1) / CHUNK_W;
    if (n_chunks == 0) begin
      n_chunks = 1;
    end
    for (int c = 0; c < n_chunks; c++) begin
      @(posedge clk);
      #1;
      in_valid    = 1'b1;
      in_req.vs2  = vs2[c*CHUNK_W +: CHUNK_W];
      in_req.v0   = v0[c*CHUNK_W +: CHUNK_W];
      in_req.vm   = vm;
      in_req.vl   = vfirst_pkg::vl_t'(vl);
      in_req.last = (c == n_chunks - 1);
      if (in_req.last) begin
        exp_q.push_back(first_active(vs2, v0, vm, vl));
        exp_cycle_q.push_back(cycle_cnt + 2);
      end
    end
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #1;
      in_valid = 1'b0;
      in_req   = '0;
    end
  endtask

  // every result pulse is compared with the head of the queue at the falling edge
  initial begin : result_check
    vfirst_pkg::xlen_t exp_val;
    int                exp_cyc;
    while (!checks_done) begin
      @(negedge clk);
      if (rst) begin
        if (cycle_cnt > 0 && out_valid !== 1'b0) begin
          other_errors++;
          $display("out_valid was not low during reset at time %0t", $time);
        end
      end else if (out_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("result pulse at time %0t with no instruction outstanding", $time);
        end else begin
          exp_val = exp_q.pop_front();
          exp_cyc = exp_cycle_q.pop_front();
          if (out_rd !== exp_val) begin
            value_errors++;
            $display("CHECK FAILED at %0t: out_rd expected 0x%0h, got 0x%0h",
                     $time, exp_val, out_rd);
          end
          if (cycle_cnt != exp_cyc) begin
            timing_errors++;
            $display("result arrived in cycle %0d but was due in cycle %0d", cycle_cnt, exp_cyc);
          end
        end
      end else if (exp_cycle_q.size() > 0 && cycle_cnt > exp_cycle_q[0]) begin
        // the pulse for the head instruction never came
        other_errors++;
        $display("result due in cycle %0d did not arrive", exp_cycle_q[0]);
        exp_val = exp_q.pop_front();
        exp_cyc = exp_cycle_q.pop_front();
      end
    end
  end

  initial begin : driver
    logic [MAX_ELEMS-1:0] vs2;
    logic [MAX_ELEMS-1:0] v0;
    logic                 vm;
    int                   vl;
    int                   wait_cnt;
    int                   total;
    lfsr_state = 32'h54352813;
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_req     = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    // one set bit in a single unmasked chunk
    vs2 = '0;
    v0  = '0;
    vs2[37] = 1'b1;
    send_instr(vs2, v0, 1'b1, 64);
    vs2 = '0;
    vs2[0] = 1'b1;
    send_instr(vs2, v0, 1'b1, 64);
    idle_cycles(2);

    // first hit in a later chunk with more hits behind it
    vs2 = '0;
    vs2[200] = 1'b1;
    vs2[210] = 1'b1;
    vs2[290] = 1'b1;
    send_instr(vs2, v0, 1'b1, 300);

    // nothing active, vl of zero included
    vs2 = '1;
    send_instr(vs2, v0, 1'b1, 0);
    vs2 = '0;
    send_instr(vs2, v0, 1'b1, 128);
    idle_cycles(1);

    // tail bits at and above vl are ignored, a bit just below vl is found
    vs2 = '0;
    vs2[100] = 1'b1;
    vs2[120] = 1'b1;
    send_instr(vs2, v0, 1'b1, 100);
    vs2[99] = 1'b1;
    send_instr(vs2, v0, 1'b1, 100);

    // masked, only bit 20 is set in both vs2 and v0
    vs2 = '0;
    vs2[3]  = 1'b1;
    vs2[7]  = 1'b1;
    vs2[20] = 1'b1;
    v0[5]   = 1'b1;
    v0[20]  = 1'b1;
    v0[40]  = 1'b1;
    send_instr(vs2, v0, 1'b0, 64);
    idle_cycles(3);

    // random instructions with no gap between them
    for (int n = 0; n < NUM_RANDOM; n++) begin
      vl  = rand_bits(11) % (MAX_ELEMS + 1);
      vm  = rand_bits(1);
      vs2 = sparse_vector(7);
      v0  = sparse_vector(3);
      send_instr(vs2, v0, vm, vl);
    end
    idle_cycles(1);

    wait_cnt = 0;
    while (exp_q.size() > 0 && wait_cnt < DRAIN_TIMEOUT) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("timed out with %0d results still outstanding", exp_q.size());
    end
    // a few quiet cycles so that a stray pulse is still caught
    repeat (4) @(posedge clk);
    checks_done = 1'b1;

    total = value_errors + timing_errors + other_errors;
    $display("errors: value %0d, timing %0d, other %0d", value_errors, timing_errors,
             other_errors);
    if (total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// free-running clock for the testbench
module tb_clock_gen #(
  parameter int HALF_PERIOD_NS = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD_NS) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/vfirst_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

// vfirst.m over a stream of mask chunks
// the result leaves two cycles after the last chunk of an instruction
module vfirst_unit (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    in_valid,
  input  wire vfirst_pkg::chunk_req_t  in_req,
  output logic                         out_valid,
  output vfirst_pkg::xlen_t            out_rd
);

  vfirst_pkg::chunk_t    prep_active;
  vfirst_pkg::elem_idx_t prep_base;
  logic                  prep_last;
  logic                  prep_valid;

  logic                  hit_valid;
  vfirst_pkg::hit_t      hit;

  // masking and tail clearing without a register
  mask_chunk_prep u_prep (
    .clk     (clk),
    .rst     (rst),
    .in_valid(in_valid),
    .in_req  (in_req),
    .active  (prep_active),
    .base    (prep_base),
    .last    (prep_last),
    .valid   (prep_valid)
  );

  // registered search for the first set bit of each chunk
  vfirst_bit u_bit (
    .clk      (clk),
    .rst      (rst),
    .in_valid (prep_valid),
    .in_idx   (prep_base),
    .in_m0    (prep_active),
    .in_last  (prep_last),
    .out_valid(hit_valid),
    .out_hit  (hit)
  );

  // registered merge of the hits across one instruction
  vfirst_reduce u_reduce (
    .clk      (clk),
    .rst      (rst),
    .hit_valid(hit_valid),
    .hit      (hit),
    .out_valid(out_valid),
    .out_rd   (out_rd)
  );

endmodule

`default_nettype wire

// ==== verilog/vfirst_reduce.sv ====
`timescale 1ns/1ps
`default_nettype none

// merges the per-chunk hits of one instruction into the vfirst result
module vfirst_reduce (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              hit_valid,
  input  wire vfirst_pkg::hit_t  hit,
  output logic                   out_valid,
  output vfirst_pkg::xlen_t      out_rd
);

  logic                  seen_q;
  vfirst_pkg::elem_idx_t first_q;
  logic                  any_seen;
  vfirst_pkg::elem_idx_t first_idx;

  // chunks come lowest first, so a hit already seen always wins
  // over a hit in a later chunk
  always_comb begin
    any_seen  = seen_q | hit.found;
    first_idx = seen_q ? first_q : hit.idx;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      seen_q    <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= hit_valid && hit.last;
      if (hit_valid) begin
        // the last chunk closes the instruction and the next one starts clean
        if (hit.last) begin
          seen_q <= 1'b0;
        end else begin
          seen_q <= any_seen;
        end
      end
    end
  end

  // first_q only matters while seen_q is set
  always_ff @(posedge clk) begin
    if (hit_valid) begin
      first_q <= first_idx;
      if (hit.last) begin
        if (any_seen) begin
          out_rd <= vfirst_pkg::xlen_t'(first_idx);
        end else begin
          // no active bit set anywhere, vfirst returns -1
          out_rd <= '1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/vfirst_bit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vfirst_settings.svh"

// per-chunk stage that finds the first active bit and makes it absolute
module vfirst_bit (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   in_valid,
  input  wire vfirst_pkg::elem_idx_t  in_idx,
  input  wire vfirst_pkg::chunk_t     in_m0,
  input  wire logic                   in_last,
  output logic                        out_valid,
  output vfirst_pkg::hit_t            out_hit
);

  localparam int OFF_W = $clog2(`VFIRST_CHUNK_W);

  vfirst_pkg::ctz_cnt_t  count;
  logic                  valid_q;
  logic                  found_q;
  logic                  last_q;
  logic [OFF_W-1:0]      off_q;
  vfirst_pkg::elem_idx_t base_q;

  ctz #(
    .WIDTH(`VFIRST_CHUNK_W)
  ) u_ctz (
    .in (in_m0),
    .out(count)
  );

  // everything drops to zero in cycles without a chunk
  always_ff @(posedge clk) begin
    if (rst || !in_valid) begin
      valid_q <= 1'b0;
      found_q <= 1'b0;
      last_q  <= 1'b0;
      off_q   <= '0;
      base_q  <= '0;
    end else begin
      valid_q <= 1'b1;
      // the top bit of the count alone flags an empty chunk
      found_q <= ~count[OFF_W];
      last_q  <= in_last;
      off_q   <= count[OFF_W-1:0];
      base_q  <= in_idx;
    end
  end

  assign out_valid = valid_q;

  // the add is kept after the register so that the ctz tree has the cycle alone
  always_comb begin
    out_hit.found = found_q;
    out_hit.idx   = base_q + vfirst_pkg::elem_idx_t'(off_q);
    out_hit.last  = last_q;
  end

endmodule

`default_nettype wire

// ==== verilog/mask_chunk_prep.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vfirst_settings.svh"

// locates each chunk inside its instruction and clears the bits that
// do not take part in the search
module mask_chunk_prep (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    in_valid,
  input  wire vfirst_pkg::chunk_req_t  in_req,
  output vfirst_pkg::chunk_t           active,
  output vfirst_pkg::elem_idx_t        base,
  output logic                         last,
  output logic                         valid
);

  localparam int OFF_W = $clog2(`VFIRST_CHUNK_W);

  vfirst_pkg::chunk_num_t chunk_num;
  vfirst_pkg::chunk_t     in_range;

  // chunk number of the chunk on the input right now
  // it steps with every accepted chunk and restarts after the last one
  always_ff @(posedge clk) begin
    if (rst) begin
      chunk_num <= '0;
    end else if (in_valid) begin
      if (in_req.last) begin
        chunk_num <= '0;
      end else begin
        chunk_num <= chunk_num + 1'b1;
      end
    end
  end

  // chunks are a power of two wide, so the base is a plain shift
  assign base = {chunk_num, {OFF_W{1'b0}}};

  // tail bits at or above vl never count
  // base plus the bit offset stays below 1024, so vl_t cannot overflow here
  always_comb begin
    for (int i = 0; i < `VFIRST_CHUNK_W; i++) begin
      in_range[i] = (vfirst_pkg::vl_t'(base) + vfirst_pkg::vl_t'(i)) < in_req.vl;
    end
  end

  // with vm set the instruction is unmasked and v0 is ignored
  assign active = in_req.vs2 & in_range & (in_req.v0 | {`VFIRST_CHUNK_W{in_req.vm}});

  assign last  = in_req.last;
  assign valid = in_valid;

endmodule

`default_nettype wire

// ==== verilog/ctz.sv ====
`timescale 1ns/1ps
`default_nettype none

// count trailing zeros for any input width
// a result equal to WIDTH means no bit is set
module ctz #(
  parameter int WIDTH = 64
) (
  input  wire logic [WIDTH-1:0]            in,
  output logic      [$clog2(WIDTH+1)-1:0]  out
);

  // the largest power of two below WIDTH goes to the high side of the tree,
  // the rest to the low side, so L >= R always holds
  localparam int L = (WIDTH >= 2) ? 2 ** ($clog2(WIDTH) - 1) : 1;
  localparam int R = WIDTH - L;

  generate
    if (WIDTH >= 2) begin : g_tree
      ctz_tree #(
        .L(L),
        .R(R)
      ) u_tree (
        .left (in[WIDTH-1 -: L]),
        .right(in[R-1:0]),
        .out  (out)
      );
    end else begin : g_single
      // one bit needs no tree
      assign out = ~in[0];
    end
  endgenerate

endmodule

`default_nettype wire

// ==== verilog/ctz_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

// trailing-zero count of the concatenation {left, right}
// right holds the least significant bits, left is a power of two at least as wide
module ctz_tree #(
  parameter int L = 8,
  parameter int R = 8
) (
  input  wire logic [L-1:0]               left,
  input  wire logic [R-1:0]               right,
  output logic      [$clog2(L+R+1)-1:0]   out
);

  localparam int LW = $clog2(L + 1);
  localparam int RW = $clog2(R + 1);
  localparam int OW = $clog2(L + R + 1);

  // the left side always splits into two equal powers of two
  localparam int L2 = L / 2;

  // the right side splits into a power of two on top and the remainder below,
  // which keeps the L >= R rule true in the child node
  localparam int RA = (R >= 2) ? 2 ** ($clog2(R) - 1) : 1;
  localparam int RB = R - RA;

  logic [LW-1:0] lcnt;
  logic [RW-1:0] rcnt;
  logic          right_zero;

  generate
    if (L >= 2) begin : g_left_node
      ctz_tree #(
        .L(L2),
        .R(L2)
      ) u_left (
        .left (left[L-1 -: L2]),
        .right(left[L2-1:0]),
        .out  (lcnt)
      );
    end else begin : g_left_leaf
      // a single bit has a count of one when clear and zero when set
      assign lcnt = ~left[0];
    end

    if (R >= 2) begin : g_right_node
      ctz_tree #(
        .L(RA),
        .R(RB)
      ) u_right (
        .left (right[R-1 -: RA]),
        .right(right[RB-1:0]),
        .out  (rcnt)
      );
    end else begin : g_right_leaf
      assign rcnt = ~right[0];
    end
  endgenerate

  // a count equal to the width of the right half means it had no set bit
  assign right_zero = (rcnt == RW'(R));

  // when the low half is empty the search continues into the high half,
  // so its count is shifted up by the width of the low half
  // with both halves empty this gives L+R, only the top bit of out
  assign out = right_zero ? (OW'(R) + OW'(lcnt)) : OW'(rcnt);

endmodule

`default_nettype wire

// ==== verilog/vfirst_pkg.sv ====
`default_nettype none

`include "vfirst_settings.svh"

package vfirst_pkg;

  typedef logic [`VFIRST_CHUNK_W-1:0] chunk_t;
  typedef logic [`VFIRST_IDX_W-1:0] elem_idx_t;
  typedef logic [`VFIRST_VL_W-1:0] vl_t;

  // position of a chunk inside one instruction of at most 16 chunks of 64 bits
  typedef logic [`VFIRST_IDX_W-$clog2(`VFIRST_CHUNK_W)-1:0] chunk_num_t;

  // trailing-zero count whose top bit alone means the chunk is all zero
  typedef logic [$clog2(`VFIRST_CHUNK_W+1)-1:0] ctz_cnt_t;

  typedef logic [`VFIRST_XLEN-1:0] xlen_t;

  // one mask chunk together with its masking context
  typedef struct packed {
    chunk_t vs2;
    chunk_t v0;
    logic   vm;
    vl_t    vl;
    logic   last;
  } chunk_req_t;

  // per-chunk search result
  typedef struct packed {
    logic      found;
    elem_idx_t idx;
    logic      last;
  } hit_t;

endpackage

`default_nettype wire

// ==== verilog/vfirst_settings.svh ====
`ifndef VFIRST_SETTINGS_SVH
`define VFIRST_SETTINGS_SVH

// mask bits handled per chunk
`define VFIRST_CHUNK_W 64

// element index width, enough for 1024 mask elements
`define VFIRST_IDX_W 10

// vl needs one extra bit so that it can hold the full 1024
`define VFIRST_VL_W 11

// width of the scalar destination register
`define VFIRST_XLEN 64

`endif
